// ==== logic/iommu_regs_settings.svh ====
// Shared widths and register offsets of the IOMMU register slice; include it in every file that needs them.
`ifndef IOMMU_REGS_SETTINGS_SVH
`define IOMMU_REGS_SETTINGS_SVH

// Width of one register word on the software port.
`define IOMMU_DW 32

// Width of the register offset; offsets are byte addresses of 32-bit words.
`define IOMMU_AW 8

// Number of independent fault sources reported by the translation logic.
`define IOMMU_NSRC 4

// Width of the saturating fault counter inside FCNT.
`define IOMMU_CNTW 16

// Register offsets.
`define IOMMU_OFS_CTRL    8'h00
`define IOMMU_OFS_FSTAT   8'h04
`define IOMMU_OFS_IPEND   8'h08
`define IOMMU_OFS_FCNT    8'h0C
`define IOMMU_OFS_STATUS  8'h10
`define IOMMU_OFS_CMDDONE 8'h14

`endif

// ==== logic/iommu_field_pkg.sv ====
// Field access types and the control word layout; import it wherever these types are needed.
`include "iommu_regs_settings.svh"

package iommu_field_pkg;

    // Software access type of one register field.
    // WO is kept for completeness even though no register here uses it.
    // HRO means software cannot touch the field at all, only hardware.
    typedef enum logic [2:0] {
        SwAccessRW  = 3'd0,
        SwAccessRO  = 3'd1,
        SwAccessWO  = 3'd2,
        SwAccessW1S = 3'd3,
        SwAccessW1C = 3'd4,
        SwAccessW0C = 3'd5,
        SwAccessRC  = 3'd6,
        SwAccessHRO = 3'd7
    } sw_access_e;

    // Named bits of the CTRL register.
    // The enable bit gates every interrupt source.
    // The three enables below it select which pending bits may raise irq.
    typedef struct packed {
        logic [`IOMMU_DW-5:0] reserved;
        logic                 pending_ie;
        logic                 cmd_ie;
        logic                 fault_ie;
        logic                 enable;
    } ctrl_bits_t;

    // The CTRL word is stored and read back as a plain word.
    // The event logic looks at the same word through its named bits.
    typedef union packed {
        logic [`IOMMU_DW-1:0] raw;
        ctrl_bits_t           bits;
    } ctrl_reg_u;

endpackage

// ==== logic/iommu_reg_if.sv ====
// Link between the register block and the event unit; the block owns field values, the unit owns updates.
`timescale 1ns/10ps
`include "iommu_regs_settings.svh"

interface iommu_reg_if
    import iommu_field_pkg::*;
(
    input logic clk,
    input logic arst_n
);

    // Current field values, driven by the register block.
    ctrl_reg_u            ctrl;
    logic [`IOMMU_DW-1:0] fstat;
    logic [`IOMMU_DW-1:0] ipend;
    logic [`IOMMU_DW-1:0] fcnt;
    logic [`IOMMU_DW-1:0] cmddone;

    // Hardware update strobes and next values, driven by the event unit.
    logic                 ctrl_de;
    ctrl_reg_u            ctrl_d;
    logic                 fstat_de;
    logic [`IOMMU_DW-1:0] fstat_d;
    logic                 ipend_de;
    logic [`IOMMU_DW-1:0] ipend_d;
    logic                 fcnt_de;
    logic [`IOMMU_DW-1:0] fcnt_d;
    logic                 status_de;
    logic [`IOMMU_DW-1:0] status_d;
    logic                 cmddone_de;
    logic [`IOMMU_DW-1:0] cmddone_d;

    modport regs (
        output ctrl, fstat, ipend, fcnt, cmddone,
        input  ctrl_de, ctrl_d, fstat_de, fstat_d, ipend_de, ipend_d,
        input  fcnt_de, fcnt_d, status_de, status_d, cmddone_de, cmddone_d
    );

    // The event unit also gets the clock, only to check its inputs.
    modport events (
        input  clk, arst_n,
        input  ctrl, fstat, ipend, fcnt, cmddone,
        output ctrl_de, ctrl_d, fstat_de, fstat_d, ipend_de, ipend_d,
        output fcnt_de, fcnt_d, status_de, status_d, cmddone_de, cmddone_d
    );

endinterface

// ==== logic/iommu_field_arb.sv ====
// Write arbiter of one register field; merges the software and hardware requests by access type.
`timescale 1ns/10ps
`include "iommu_regs_settings.svh"

module iommu_field_arb
    import iommu_field_pkg::*;
#(
    parameter int         DW       = `IOMMU_DW,
    parameter sw_access_e SwAccess = SwAccessRW
) (
    // Software request. For RC fields this is the read strobe, not a write.
    input  logic          we,
    input  logic [DW-1:0] wd,
    // Hardware request.
    input  logic          de,
    input  logic [DW-1:0] d,
    // Current field value, needed by the masking access types.
    input  logic [DW-1:0] q,
    // Resulting write to the field flops.
    output logic          wr_en,
    output logic [DW-1:0] wr_data
);

    if (SwAccess inside {SwAccessRW, SwAccessWO}) begin : gen_rw
        // Plain write access.
        // Software takes priority when both sides write in the same cycle.
        assign wr_en   = we | de;
        assign wr_data = we ? wd : d;
    end else if (SwAccess == SwAccessRO) begin : gen_ro
        // Software only reads, so only hardware loads the field.
        assign wr_en   = de;
        assign wr_data = d;
    end else if (SwAccess == SwAccessW1S) begin : gen_w1s
        // Ones written by software are ORed into the hardware value.
        // When hardware is idle they go into the current value instead.
        assign wr_en   = we | de;
        assign wr_data = (de ? d : q) | (we ? wd : '0);
    end else if (SwAccess == SwAccessW1C) begin : gen_w1c
        // Ones written by software clear bits.
        // A hardware set on the same bit in the same cycle is lost.
        assign wr_en   = we | de;
        assign wr_data = (de ? d : q) & (we ? ~wd : '1);
    end else if (SwAccess == SwAccessW0C) begin : gen_w0c
        // Zeros written by software clear bits; ones leave them alone.
        assign wr_en   = we | de;
        assign wr_data = (de ? d : q) & (we ? wd : '1);
    end else if (SwAccess == SwAccessRC) begin : gen_rc
        // A read clears the whole field.
        // An increment that lands in the same cycle is dropped.
        assign wr_en   = we | de;
        assign wr_data = (de ? d : q) & (we ? '0 : '1);
    end else begin : gen_hro
        // Hardware-only field, invisible to software writes.
        assign wr_en   = de;
        assign wr_data = d;
    end

endmodule

// ==== logic/iommu_field_reg.sv ====
// One register field, an arbiter in front of its flops; instantiate one per field of the register block.
`timescale 1ns/10ps
`include "iommu_regs_settings.svh"

module iommu_field_reg
    import iommu_field_pkg::*;
#(
    parameter int            DW       = `IOMMU_DW,
    parameter sw_access_e    SwAccess = SwAccessRW,
    parameter logic [DW-1:0] ResetVal = '0
) (
    input  logic          clk,
    input  logic          arst_n,
    input  logic          we,
    input  logic [DW-1:0] wd,
    input  logic          de,
    input  logic [DW-1:0] d,
    output logic [DW-1:0] q
);

    logic          wr_en;
    logic [DW-1:0] wr_data;

    // The arbiter decides whether and what to write this cycle.
    iommu_field_arb #(
        .DW       (DW),
        .SwAccess (SwAccess)
    ) u_field_arb (
        .we      (we),
        .wd      (wd),
        .de      (de),
        .d       (d),
        .q       (q),
        .wr_en   (wr_en),
        .wr_data (wr_data)
    );

    // Field storage; it holds its value until the arbiter enables a write.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            q <= ResetVal;
        end else if (wr_en) begin
            q <= wr_data;
        end
    end

    // The register block must never route a software strobe to a read-only field.
    if (SwAccess inside {SwAccessRO, SwAccessHRO}) begin : gen_ro_check
        a_ro_no_we : assert property (@(posedge clk) disable iff (!arst_n) !we)
            else $error("software strobe reached a read-only field");
    end

endmodule

// ==== logic/iommu_reg_block.sv ====
// Software-visible register block; decodes the register port and holds all six fields.
`timescale 1ns/10ps
`include "iommu_regs_settings.svh"

module iommu_reg_block
    import iommu_field_pkg::*;
(
    input  logic                 clk,
    input  logic                 arst_n,
    input  logic                 wr,
    input  logic                 rd,
    input  logic [`IOMMU_AW-1:0] addr,
    input  logic [`IOMMU_DW-1:0] wdata,
    output logic [`IOMMU_DW-1:0] rdata,
    iommu_reg_if.regs            regs
);

    // Per-field software strobes.
    logic wr_ctrl;
    logic wr_fstat;
    logic wr_ipend;
    logic wr_cmddone;
    logic rd_fcnt;

    // Local copies of the field values, used by the read-back mux.
    logic [`IOMMU_DW-1:0] ctrl_q;
    logic [`IOMMU_DW-1:0] fstat_q;
    logic [`IOMMU_DW-1:0] ipend_q;
    logic [`IOMMU_DW-1:0] fcnt_q;
    logic [`IOMMU_DW-1:0] status_q;
    logic [`IOMMU_DW-1:0] cmddone_q;

    assign wr_ctrl    = wr && (addr == `IOMMU_OFS_CTRL);
    assign wr_fstat   = wr && (addr == `IOMMU_OFS_FSTAT);
    assign wr_ipend   = wr && (addr == `IOMMU_OFS_IPEND);
    assign wr_cmddone = wr && (addr == `IOMMU_OFS_CMDDONE);
    // FCNT clears on read, so its strobe comes from the read side.
    assign rd_fcnt    = rd && (addr == `IOMMU_OFS_FCNT);

    iommu_field_reg #(.SwAccess(SwAccessRW)) u_ctrl (
        .clk (clk), .arst_n (arst_n),
        .we  (wr_ctrl), .wd (wdata),
        .de  (regs.ctrl_de), .d (regs.ctrl_d.raw),
        .q   (ctrl_q)
    );

    iommu_field_reg #(.SwAccess(SwAccessW1C)) u_fstat (
        .clk (clk), .arst_n (arst_n),
        .we  (wr_fstat), .wd (wdata),
        .de  (regs.fstat_de), .d (regs.fstat_d),
        .q   (fstat_q)
    );

    iommu_field_reg #(.SwAccess(SwAccessW1S)) u_ipend (
        .clk (clk), .arst_n (arst_n),
        .we  (wr_ipend), .wd (wdata),
        .de  (regs.ipend_de), .d (regs.ipend_d),
        .q   (ipend_q)
    );

    iommu_field_reg #(.SwAccess(SwAccessRC)) u_fcnt (
        .clk (clk), .arst_n (arst_n),
        .we  (rd_fcnt), .wd (wdata),
        .de  (regs.fcnt_de), .d (regs.fcnt_d),
        .q   (fcnt_q)
    );

    // STATUS is read-only; writes to its offset are ignored.
    iommu_field_reg #(.SwAccess(SwAccessRO)) u_status (
        .clk (clk), .arst_n (arst_n),
        .we  (1'b0), .wd (wdata),
        .de  (regs.status_de), .d (regs.status_d),
        .q   (status_q)
    );

    iommu_field_reg #(.SwAccess(SwAccessW0C)) u_cmddone (
        .clk (clk), .arst_n (arst_n),
        .we  (wr_cmddone), .wd (wdata),
        .de  (regs.cmddone_de), .d (regs.cmddone_d),
        .q   (cmddone_q)
    );

    // Field values go out to the event unit.
    assign regs.ctrl.raw = ctrl_q;
    assign regs.fstat    = fstat_q;
    assign regs.ipend    = ipend_q;
    assign regs.fcnt     = fcnt_q;
    assign regs.cmddone  = cmddone_q;

    // Registered read-back; rdata keeps the last result until the next read.
    // FCNT returns its value from before the clear that happens at this edge.
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            rdata <= '0;
        end else if (rd) begin
            case (addr)
                `IOMMU_OFS_CTRL:    rdata <= ctrl_q;
                `IOMMU_OFS_FSTAT:   rdata <= fstat_q;
                `IOMMU_OFS_IPEND:   rdata <= ipend_q;
                `IOMMU_OFS_FCNT:    rdata <= fcnt_q;
                `IOMMU_OFS_STATUS:  rdata <= status_q;
                `IOMMU_OFS_CMDDONE: rdata <= cmddone_q;
                default:            rdata <= '0;
            endcase
        end
    end

    // The port has no arbitration, so a write and a read never share a cycle.
    a_no_wr_rd : assert property (@(posedge clk) disable iff (!arst_n) !(wr && rd))
        else $error("write and read strobes high together");

    // Every access targets a whole word.
    a_aligned : assert property (@(posedge clk) disable iff (!arst_n)
        (wr || rd) |-> (addr[1:0] == 2'b00))
        else $error("unaligned register access");

endmodule

// ==== logic/iommu_event_unit.sv ====
// Event logic behind the registers; turns fault and command pulses into field updates and irq.
`timescale 1ns/10ps
`include "iommu_regs_settings.svh"

module iommu_event_unit (
    input  logic [`IOMMU_NSRC-1:0] fault,
    input  logic                   fatal,
    input  logic                   cmd_done,
    input  logic                   irq_ack,
    output logic                   irq,
    iommu_reg_if.events            events
);

    logic                   any_fault;
    logic [`IOMMU_CNTW-1:0] cnt;
    logic [3:0]             irq_mask;

    assign any_fault = |fault;
    assign cnt       = events.fcnt[`IOMMU_CNTW-1:0];

    // A fatal fault drops the global enable; the other CTRL bits keep their value.
    assign events.ctrl_de = fatal;
    always_comb begin
        events.ctrl_d             = events.ctrl;
        events.ctrl_d.bits.enable = 1'b0;
    end

    // New fault bits are added to FSTAT, and the fault counter saturates.
    assign events.fstat_de = any_fault;
    assign events.fcnt_de  = any_fault;
    always_comb begin
        events.fstat_d                      = events.fstat;
        events.fstat_d[`IOMMU_NSRC-1:0]     = events.fstat[`IOMMU_NSRC-1:0] | fault;
        events.fcnt_d                       = '0;
        events.fcnt_d[`IOMMU_CNTW-1:0]      = (&cnt) ? cnt : cnt + 1'b1;
    end

    // STATUS holds the lowest faulting index in bits 7:0 and a valid flag in the top bit.
    // The loop runs downwards so the lowest index is the last one to win.
    assign events.status_de = any_fault;
    always_comb begin
        events.status_d = '0;
        for (int i = `IOMMU_NSRC - 1; i >= 0; i--) begin
            if (fault[i]) begin
                events.status_d[7:0] = 8'(i);
            end
        end
        events.status_d[`IOMMU_DW-1] = 1'b1;
    end

    // Command completion is sticky until software writes a zero.
    assign events.cmddone_de = cmd_done;
    assign events.cmddone_d  = events.cmddone | `IOMMU_DW'(1);

    // Bit 0 of IPEND marks a fault and bit 1 marks a command completion.
    // An acknowledge wipes old pending bits, but events of the same cycle still land.
    assign events.ipend_de = any_fault | cmd_done | irq_ack;
    assign events.ipend_d  = (irq_ack ? '0 : events.ipend) | {cmd_done, any_fault};

    // Bits 2 and 3 are only ever set by software and share one enable.
    assign irq_mask = {events.ctrl.bits.pending_ie, events.ctrl.bits.pending_ie,
                       events.ctrl.bits.cmd_ie, events.ctrl.bits.fault_ie};
    assign irq      = events.ctrl.bits.enable & (|(events.ipend[3:0] & irq_mask));

    // The translation logic only flags fatal on a cycle that carries a fault.
    a_fatal_with_fault : assert property (@(posedge events.clk)
        disable iff (!events.arst_n) fatal |-> any_fault)
        else $error("fatal raised without a fault");

endmodule

// ==== logic/iommu_regs_top.sv ====
// Top level of the IOMMU register slice; exposes the register port and event pins as plain ports.
`timescale 1ns/10ps
`include "iommu_regs_settings.svh"

module iommu_regs_top (
    input  logic                   clk,
    input  logic                   arst_n,
    // Software register port.
    input  logic                   wr,
    input  logic                   rd,
    input  logic [`IOMMU_AW-1:0]   addr,
    input  logic [`IOMMU_DW-1:0]   wdata,
    output logic [`IOMMU_DW-1:0]   rdata,
    // Events from the translation logic.
    input  logic [`IOMMU_NSRC-1:0] fault,
    input  logic                   fatal,
    input  logic                   cmd_done,
    input  logic                   irq_ack,
    output logic                   irq
);

    // Field values and hardware updates travel between the two blocks here.
    iommu_reg_if u_reg_if (
        .clk    (clk),
        .arst_n (arst_n)
    );

    // Register block with its six fields and the read-back path.
    iommu_reg_block u_reg_block (
        .clk    (clk),
        .arst_n (arst_n),
        .wr     (wr),
        .rd     (rd),
        .addr   (addr),
        .wdata  (wdata),
        .rdata  (rdata),
        .regs   (u_reg_if.regs)
    );

    // Event logic; it has no state of its own.
    iommu_event_unit u_event_unit (
        .fault    (fault),
        .fatal    (fatal),
        .cmd_done (cmd_done),
        .irq_ack  (irq_ack),
        .irq      (irq),
        .events   (u_reg_if.events)
    );

endmodule

// ==== tb/iommu_regs_tb.sv ====
// Testbench of the IOMMU register slice; drives the register port and event pins and checks read-back and irq.
`timescale 1ns/10ps
`include "iommu_regs_settings.svh"

module iommu_regs_tb;

    logic                   clk;
    logic                   arst_n;
    logic                   wr;
    logic                   rd;
    logic [`IOMMU_AW-1:0]   addr;
    logic [`IOMMU_DW-1:0]   wdata;
    logic [`IOMMU_DW-1:0]   rdata;
    logic [`IOMMU_NSRC-1:0] fault;
    logic                   fatal;
    logic                   cmd_done;
    logic                   irq_ack;
    logic                   irq;
    int                     errors;
    int                     checks;
    int                     n_faults;
    logic [`IOMMU_NSRC-1:0] last_mask;
    logic [`IOMMU_DW-1:0]   ctrl_val;
    logic [`IOMMU_DW-1:0]   status_now;

    iommu_regs_top u_iommu_regs_top (
        .clk (clk), .arst_n (arst_n), .wr (wr), .rd (rd), .addr (addr),
        .wdata (wdata), .rdata (rdata), .fault (fault), .fatal (fatal),
        .cmd_done (cmd_done), .irq_ack (irq_ack), .irq (irq)
    );

    // 8 ns clock.
    initial clk = 1'b0;
    always #4 clk = ~clk;

    // rdata only changes on a read strobe.
    a_rdata_hold : assert property (@(posedge clk) disable iff (!arst_n) !rd |=> $stable(rdata))
        else begin
            errors++;
            $display("[ERROR] rdata_hold: expected %h, actual %h", $past(rdata), rdata);
        end

    // An acknowledge with no new event in the same cycle leaves nothing pending.
    a_ack_drops_irq : assert property (@(posedge clk) disable iff (!arst_n)
        (irq_ack && !(|fault) && !cmd_done) |=> !irq)
        else begin
            errors++;
            $display("[ERROR] ack_drops_irq: expected 0, actual %b", irq);
        end

    // STATUS holds the lowest faulting source in bits 7:0 and a valid flag in bit 31.
    function automatic logic [`IOMMU_DW-1:0] expected_status(input logic [`IOMMU_NSRC-1:0] m);
        logic [`IOMMU_DW-1:0] v;
        logic                 found;
        v     = '0;
        found = 1'b0;
        for (int i = 0; i < `IOMMU_NSRC; i++) begin
            if (m[i] && !found) begin
                v[7:0] = 8'(i);
                found  = 1'b1;
            end
        end
        v[`IOMMU_DW-1] = 1'b1;
        return v;
    endfunction

    task automatic write_reg(input logic [`IOMMU_AW-1:0] a, input logic [`IOMMU_DW-1:0] d);
        @(negedge clk);
        wr    = 1'b1;
        addr  = a;
        wdata = d;
        @(negedge clk);
        wr    = 1'b0;
    endtask

    // The result is sampled one cycle after the strobe, at the falling edge.
    task automatic read_check(input logic [`IOMMU_AW-1:0] a, input logic [`IOMMU_DW-1:0] exp,
                              input string name);
        @(negedge clk);
        rd   = 1'b1;
        addr = a;
        @(negedge clk);
        rd   = 1'b0;
        checks++;
        assert (rdata === exp)
            else begin
                errors++;
                $display("[ERROR] %s: expected %h, actual %h", name, exp, rdata);
            end
    endtask

    // One cycle of event pulses; all are low again at the next falling edge.
    task automatic pulse_events(input logic [`IOMMU_NSRC-1:0] m, input logic fat,
                                input logic cmd, input logic ack);
        @(negedge clk);
        fault    = m;
        fatal    = fat;
        cmd_done = cmd;
        irq_ack  = ack;
        @(negedge clk);
        fault    = '0;
        fatal    = 1'b0;
        cmd_done = 1'b0;
        irq_ack  = 1'b0;
    endtask

    task automatic check_irq(input logic exp, input string name);
        checks++;
        assert (irq === exp)
            else begin
                errors++;
                $display("[ERROR] %s: expected %b, actual %b", name, exp, irq);
            end
    endtask

    // Waits at falling edges until irq reaches the level, giving up after max_cycles.
    task automatic wait_irq(input logic level, input int max_cycles, input string name);
        int n;
        n = 0;
        while (irq !== level && n < max_cycles) begin
            @(negedge clk);
            n++;
        end
        if (irq !== level) begin
            errors++;
            $display("[ERROR] %s: irq never reached %b within %0d cycles", name, level, max_cycles);
        end
    endtask

    // Watchdog for the whole run.
    initial begin
        #200000;
        $display("Timeout: the run did not reach its end in time");
        $display("Simulation finished: FAIL");
        $finish;
    end

    initial begin
        void'($urandom(32'h2293611b));
        errors   = 0;
        checks   = 0;
        arst_n   = 1'b0;
        wr       = 1'b0;
        rd       = 1'b0;
        addr     = '0;
        wdata    = '0;
        fault    = '0;
        fatal    = 1'b0;
        cmd_done = 1'b0;
        irq_ack  = 1'b0;
        repeat (5) @(posedge clk);
        @(negedge clk);
        arst_n = 1'b1;
        check_irq(1'b0, "reset_irq");

        // Every register is zero after reset, then a random CTRL word reads back.
        read_check(`IOMMU_OFS_CTRL, '0, "reset_ctrl");
        read_check(`IOMMU_OFS_FSTAT, '0, "reset_fstat");
        read_check(`IOMMU_OFS_IPEND, '0, "reset_ipend");
        read_check(`IOMMU_OFS_FCNT, '0, "reset_fcnt");
        read_check(`IOMMU_OFS_STATUS, '0, "reset_status");
        read_check(`IOMMU_OFS_CMDDONE, '0, "reset_cmddone");
        ctrl_val = $urandom;
        write_reg(`IOMMU_OFS_CTRL, ctrl_val);
        read_check(`IOMMU_OFS_CTRL, ctrl_val, "ctrl_rw");
        write_reg(`IOMMU_OFS_CTRL, '0);

        // FSTAT clears on ones, and software wins over a fault on the same bit.
        pulse_events(4'b0101, 1'b0, 1'b0, 1'b0);
        read_check(`IOMMU_OFS_FSTAT, 32'h5, "fstat_set");
        write_reg(`IOMMU_OFS_FSTAT, 32'h1);
        read_check(`IOMMU_OFS_FSTAT, 32'h4, "fstat_w1c");
        @(negedge clk);
        wr    = 1'b1;
        addr  = `IOMMU_OFS_FSTAT;
        wdata = 32'h4;
        fault = 4'b0100;
        @(negedge clk);
        wr    = 1'b0;
        fault = '0;
        read_check(`IOMMU_OFS_FSTAT, 32'h0, "fstat_sw_wins");
        // IPEND is set by software ones and wiped by an acknowledge.
        read_check(`IOMMU_OFS_IPEND, 32'h1, "ipend_fault");
        pulse_events('0, 1'b0, 1'b0, 1'b1);
        read_check(`IOMMU_OFS_IPEND, 32'h0, "ipend_ack");
        write_reg(`IOMMU_OFS_IPEND, 32'hC);
        read_check(`IOMMU_OFS_IPEND, 32'hC, "ipend_w1s");
        pulse_events('0, 1'b0, 1'b0, 1'b1);
        read_check(`IOMMU_OFS_IPEND, 32'h0, "ipend_ack_sw");

        // FCNT counts fault cycles and clears on read.
        read_check(`IOMMU_OFS_FCNT, 32'd2, "fcnt_prior");
        read_check(`IOMMU_OFS_FCNT, 32'd0, "fcnt_cleared");
        n_faults = $urandom_range(3, 10);
        for (int i = 0; i < n_faults; i++) begin
            @(negedge clk);
            last_mask = `IOMMU_NSRC'(($urandom % 15) + 1);
            fault     = last_mask;
        end
        @(negedge clk);
        fault = '0;
        read_check(`IOMMU_OFS_FCNT, `IOMMU_DW'(n_faults), "fcnt_count");
        read_check(`IOMMU_OFS_FCNT, 32'd0, "fcnt_rc");

        // STATUS shows the last lowest index and ignores writes; CMDDONE clears on zero.
        status_now = expected_status(last_mask);
        read_check(`IOMMU_OFS_STATUS, status_now, "status_index");
        write_reg(`IOMMU_OFS_STATUS, '0);
        read_check(`IOMMU_OFS_STATUS, status_now, "status_ro");
        pulse_events('0, 1'b0, 1'b1, 1'b0);
        read_check(`IOMMU_OFS_CMDDONE, 32'h1, "cmddone_set");
        write_reg(`IOMMU_OFS_CMDDONE, '1);
        read_check(`IOMMU_OFS_CMDDONE, 32'h1, "cmddone_w0c_ones");
        write_reg(`IOMMU_OFS_CMDDONE, 32'hFFFF_FFFE);
        read_check(`IOMMU_OFS_CMDDONE, 32'h0, "cmddone_w0c");

        // Interrupts follow pending bits through their enables.
        pulse_events('0, 1'b0, 1'b0, 1'b1);
        write_reg(`IOMMU_OFS_CTRL, 32'h3);
        check_irq(1'b0, "irq_idle");
        pulse_events('0, 1'b0, 1'b1, 1'b0);
        check_irq(1'b0, "irq_cmd_masked");
        write_reg(`IOMMU_OFS_CTRL, 32'h7);
        check_irq(1'b1, "irq_cmd_enabled");
        pulse_events('0, 1'b0, 1'b0, 1'b1);
        wait_irq(1'b0, 1, "irq_cmd_ack");
        pulse_events(4'b0010, 1'b0, 1'b0, 1'b0);
        check_irq(1'b1, "irq_fault");
        pulse_events('0, 1'b0, 1'b0, 1'b1);
        check_irq(1'b0, "irq_fault_ack");
        write_reg(`IOMMU_OFS_IPEND, 32'h4);
        check_irq(1'b0, "irq_sw_masked");
        write_reg(`IOMMU_OFS_CTRL, 32'hF);
        check_irq(1'b1, "irq_sw_enabled");
        pulse_events('0, 1'b0, 1'b0, 1'b1);
        check_irq(1'b0, "irq_sw_ack");
        // A fatal fault drops the enable in the same edge that records it.
        pulse_events(4'b1000, 1'b1, 1'b0, 1'b0);
        check_irq(1'b0, "irq_fatal");
        read_check(`IOMMU_OFS_CTRL, 32'hE, "ctrl_fatal");
        write_reg(`IOMMU_OFS_CTRL, 32'hF);
        check_irq(1'b1, "irq_reenabled");
        pulse_events('0, 1'b0, 1'b0, 1'b1);
        wait_irq(1'b0, 1, "irq_final_ack");

        repeat (2) @(negedge clk);
        $display("Checks run: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== all.f ====
+incdir+logic
logic/iommu_field_pkg.sv
logic/iommu_reg_if.sv
logic/iommu_field_arb.sv
logic/iommu_field_reg.sv
logic/iommu_reg_block.sv
logic/iommu_event_unit.sv
logic/iommu_regs_top.sv
tb/iommu_regs_tb.sv
